/* Makefile */
# Verilator build and run of the cache miss handler testbench

VERILATOR ?= verilator
TOP       ?= cache_miss_tb
FILELIST  ?= cache_miss.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* cache_miss.f */
hw/cache_geom_pkg.sv
hw/cache_miss_pkg.sv
hw/cache_victim_select.sv
hw/cache_lru_update.sv
hw/cache_miss_fsm.sv
hw/cache_miss.sv
test/cache_miss_tb.sv

/* hw/cache_geom_pkg.sv */
// --------------------------------------------------------------------------
// Fixed geometry of the write-back cache served by the miss handler.
// Address fields, way and set widths and LRU width all come from here.
// Modules import it by wildcard and use scoped names in their port lists.
// --------------------------------------------------------------------------

package cache_geom_pkg;

  // byte address width
  localparam int ADDR_WIDTH = 32;

  // associativity
  localparam int WAYS = 4;
  localparam int LG_WAYS = $clog2(WAYS);

  // number of sets and the width of the set index
  localparam int SETS = 64;
  localparam int LG_SETS = $clog2(SETS);

  // 8 words of 4 bytes per block
  localparam int BLOCK_OFFSET_WIDTH = 5;

  // address layout is tag | set index | block offset
  localparam int TAG_OFFSET = BLOCK_OFFSET_WIDTH + LG_SETS;
  localparam int TAG_WIDTH = ADDR_WIDTH - TAG_OFFSET;

  // pseudo-tree LRU keeps one bit per internal tree node
  localparam int LRU_WIDTH = WAYS - 1;

endpackage

/* hw/cache_lru_update.sv */
// --------------------------------------------------------------------------
// Pseudo-tree LRU update for a fill.
// For the given way, drives the tree-path bits so they point away from it,
// with a write mask that covers only those path bits.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_lru_update (
  input  logic [cache_geom_pkg::LG_WAYS-1:0]   way_i,
  output logic [cache_geom_pkg::LRU_WIDTH-1:0] lru_data_o,
  output logic [cache_geom_pkg::LRU_WIDTH-1:0] lru_mask_o
);

  import cache_geom_pkg::*;

  always_comb begin
    lru_data_o = '0;
    lru_mask_o = '0;

    // root points to the other pair
    lru_data_o[0] = ~way_i[1];
    lru_mask_o[0] = 1'b1;

    // inside the pair, point to the sibling way
    if (way_i[1]) begin
      lru_data_o[2] = ~way_i[0];
      lru_mask_o[2] = 1'b1;
    end else begin
      lru_data_o[1] = ~way_i[0];
      lru_mask_o[1] = 1'b1;
    end
  end

  // a 4-way tree path is always root plus one leaf node
  always_comb begin
    assert final ($countones(lru_mask_o) == 2)
      else $error("lru mask %b does not cover one tree path", lru_mask_o);
  end

endmodule

/* hw/cache_miss.sv */
// --------------------------------------------------------------------------
// Top level of the cache miss handler.
// Victim selection and LRU-update encoding run side by side and feed the
// miss FSM, which drives the DMA engine, tag and status memories and the
// pipeline handshake.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_miss (
  input  logic                                     clk_i,
  input  logic                                     reset_i,

  input  logic                                     miss_v_i,
  input  cache_miss_pkg::cache_op_e                op_i,
  input  logic [cache_geom_pkg::ADDR_WIDTH-1:0]    addr_i,
  input  logic [cache_geom_pkg::WAYS-1:0]          valid_i,
  input  logic [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::TAG_WIDTH-1:0] tag_i,
  input  logic [cache_geom_pkg::WAYS-1:0]          tag_hit_i,
  input  logic [cache_geom_pkg::LG_WAYS-1:0]       tag_hit_way_i,
  input  logic                                     tag_hit_found_i,
  input  logic                                     sbuf_empty_i,
  input  logic [cache_geom_pkg::WAYS-1:0]          stat_dirty_i,
  input  logic [cache_geom_pkg::LRU_WIDTH-1:0]     stat_lru_i,

  output cache_miss_pkg::dma_cmd_e                 dma_cmd_o,
  output logic [cache_geom_pkg::LG_WAYS-1:0]       dma_way_o,
  output logic [cache_geom_pkg::ADDR_WIDTH-1:0]    dma_addr_o,
  input  logic                                     dma_done_i,

  output logic                                     stat_mem_v_o,
  output logic                                     stat_mem_w_o,
  output logic [cache_geom_pkg::LG_SETS-1:0]       stat_mem_addr_o,
  output logic [cache_geom_pkg::WAYS-1:0]          stat_dirty_o,
  output logic [cache_geom_pkg::WAYS-1:0]          stat_dirty_mask_o,
  output logic [cache_geom_pkg::LRU_WIDTH-1:0]     stat_lru_o,
  output logic [cache_geom_pkg::LRU_WIDTH-1:0]     stat_lru_mask_o,

  output logic                                     tag_mem_v_o,
  output logic                                     tag_mem_w_o,
  output logic [cache_geom_pkg::LG_SETS-1:0]       tag_mem_addr_o,
  output logic [cache_geom_pkg::TAG_WIDTH-1:0]     tag_o,
  output logic                                     tag_valid_o,
  output logic [cache_geom_pkg::WAYS-1:0]          tag_mask_o,

  output logic                                     recover_o,
  output logic                                     done_o,
  output logic [cache_geom_pkg::LG_WAYS-1:0]       chosen_way_o,
  output logic                                     busy_o,
  input  logic                                     ack_i
);

  import cache_geom_pkg::*;

  logic [LG_WAYS-1:0]   victim_way;
  logic [LRU_WIDTH-1:0] lru_data;
  logic [LRU_WIDTH-1:0] lru_mask;

  cache_victim_select victim_select_i (
    .valid_i      (valid_i),
    .lru_i        (stat_lru_i),
    .victim_way_o (victim_way)
  );

  // LRU path follows the registered way, which is stable during the fetch
  cache_lru_update lru_update_i (
    .way_i      (chosen_way_o),
    .lru_data_o (lru_data),
    .lru_mask_o (lru_mask)
  );

  cache_miss_fsm miss_fsm_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .miss_v_i          (miss_v_i),
    .op_i              (op_i),
    .addr_i            (addr_i),
    .valid_i           (valid_i),
    .tag_i             (tag_i),
    .tag_hit_i         (tag_hit_i),
    .tag_hit_way_i     (tag_hit_way_i),
    .tag_hit_found_i   (tag_hit_found_i),
    .sbuf_empty_i      (sbuf_empty_i),
    .stat_dirty_i      (stat_dirty_i),
    .victim_way_i      (victim_way),
    .lru_data_i        (lru_data),
    .lru_mask_i        (lru_mask),
    .dma_cmd_o         (dma_cmd_o),
    .dma_way_o         (dma_way_o),
    .dma_addr_o        (dma_addr_o),
    .dma_done_i        (dma_done_i),
    .stat_mem_v_o      (stat_mem_v_o),
    .stat_mem_w_o      (stat_mem_w_o),
    .stat_mem_addr_o   (stat_mem_addr_o),
    .stat_dirty_o      (stat_dirty_o),
    .stat_dirty_mask_o (stat_dirty_mask_o),
    .stat_lru_o        (stat_lru_o),
    .stat_lru_mask_o   (stat_lru_mask_o),
    .tag_mem_v_o       (tag_mem_v_o),
    .tag_mem_w_o       (tag_mem_w_o),
    .tag_mem_addr_o    (tag_mem_addr_o),
    .tag_o             (tag_o),
    .tag_valid_o       (tag_valid_o),
    .tag_mask_o        (tag_mask_o),
    .recover_o         (recover_o),
    .done_o            (done_o),
    .chosen_way_o      (chosen_way_o),
    .busy_o            (busy_o),
    .ack_i             (ack_i)
  );

endmodule

/* hw/cache_miss_fsm.sv */
// --------------------------------------------------------------------------
// Miss and flush sequencer of the write-back cache.
// Waits for an empty store buffer, reads the status entry, drives the DMA
// engine through fill, eviction and fetch, then writes tag and status.
// Ends with a one-cycle recover pulse and holds done until ack_i.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_miss_fsm (
  input  logic                                     clk_i,
  input  logic                                     reset_i,

  // tag-verify stage
  input  logic                                     miss_v_i,
  input  cache_miss_pkg::cache_op_e                op_i,
  input  logic [cache_geom_pkg::ADDR_WIDTH-1:0]    addr_i,
  input  logic [cache_geom_pkg::WAYS-1:0]          valid_i,
  input  logic [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::TAG_WIDTH-1:0] tag_i,
  input  logic [cache_geom_pkg::WAYS-1:0]          tag_hit_i,
  input  logic [cache_geom_pkg::LG_WAYS-1:0]       tag_hit_way_i,
  input  logic                                     tag_hit_found_i,
  input  logic                                     sbuf_empty_i,

  // status memory read data
  input  logic [cache_geom_pkg::WAYS-1:0]          stat_dirty_i,

  // victim select and LRU update
  input  logic [cache_geom_pkg::LG_WAYS-1:0]       victim_way_i,
  input  logic [cache_geom_pkg::LRU_WIDTH-1:0]     lru_data_i,
  input  logic [cache_geom_pkg::LRU_WIDTH-1:0]     lru_mask_i,

  // DMA engine
  output cache_miss_pkg::dma_cmd_e                 dma_cmd_o,
  output logic [cache_geom_pkg::LG_WAYS-1:0]       dma_way_o,
  output logic [cache_geom_pkg::ADDR_WIDTH-1:0]    dma_addr_o,
  input  logic                                     dma_done_i,

  // status memory
  output logic                                     stat_mem_v_o,
  output logic                                     stat_mem_w_o,
  output logic [cache_geom_pkg::LG_SETS-1:0]       stat_mem_addr_o,
  output logic [cache_geom_pkg::WAYS-1:0]          stat_dirty_o,
  output logic [cache_geom_pkg::WAYS-1:0]          stat_dirty_mask_o,
  output logic [cache_geom_pkg::LRU_WIDTH-1:0]     stat_lru_o,
  output logic [cache_geom_pkg::LRU_WIDTH-1:0]     stat_lru_mask_o,

  // tag memory
  output logic                                     tag_mem_v_o,
  output logic                                     tag_mem_w_o,
  output logic [cache_geom_pkg::LG_SETS-1:0]       tag_mem_addr_o,
  output logic [cache_geom_pkg::TAG_WIDTH-1:0]     tag_o,
  output logic                                     tag_valid_o,
  output logic [cache_geom_pkg::WAYS-1:0]          tag_mask_o,

  // pipeline
  output logic                                     recover_o,
  output logic                                     done_o,
  output logic [cache_geom_pkg::LG_WAYS-1:0]       chosen_way_o,
  output logic                                     busy_o,
  input  logic                                     ack_i
);

  import cache_geom_pkg::*;
  import cache_miss_pkg::*;

  miss_state_e          state_r;
  miss_state_e          state_n;
  logic [LG_WAYS-1:0]   chosen_way_r;
  logic [LG_WAYS-1:0]   chosen_way_n;
  logic [LG_WAYS-1:0]   flush_way_r;
  logic [LG_WAYS-1:0]   flush_way_n;
  logic [TAG_WIDTH-1:0] addr_tag;
  logic [LG_SETS-1:0]   addr_index;
  logic [LG_WAYS-1:0]   evict_way;
  logic [WAYS-1:0]      chosen_onehot;
  logic                 start;
  logic                 flush_op;
  logic                 inval_op;
  logic                 goto_flush;
  logic [ADDR_WIDTH-1:0] fill_addr;
  logic [ADDR_WIDTH-1:0] evict_addr;

  assign addr_tag   = addr_i[TAG_OFFSET +: TAG_WIDTH];
  assign addr_index = addr_i[BLOCK_OFFSET_WIDTH +: LG_SETS];

  // op and hit are held by the tag-verify stage for the whole miss
  assign flush_op   = (op_i == OP_AFL) || (op_i == OP_AFLINV) || (op_i == OP_AINV);
  assign inval_op   = (op_i == OP_AFLINV) || (op_i == OP_AINV);
  assign goto_flush = flush_op && tag_hit_found_i;
  assign start      = miss_v_i && sbuf_empty_i;

  assign evict_way     = goto_flush ? flush_way_r : chosen_way_r;
  assign chosen_onehot = {{(WAYS - 1){1'b0}}, 1'b1} << chosen_way_r;

  // fills always start at word 0 of the block
  assign fill_addr  = {addr_tag, addr_index, {BLOCK_OFFSET_WIDTH{1'b0}}};
  assign evict_addr = {tag_i[evict_way], addr_index, {BLOCK_OFFSET_WIDTH{1'b0}}};

  assign stat_mem_addr_o = addr_index;
  assign tag_mem_addr_o  = addr_index;
  assign dma_way_o       = evict_way;
  assign chosen_way_o    = chosen_way_r;
  assign busy_o          = (state_r != ST_IDLE) && (state_r != ST_DONE);

  always_comb begin
    state_n = state_r;
    chosen_way_n = chosen_way_r;
    flush_way_n = flush_way_r;

    dma_cmd_o = DMA_NOP;
    dma_addr_o = '0;

    stat_mem_v_o = 1'b0;
    stat_mem_w_o = 1'b0;
    stat_dirty_o = '0;
    stat_dirty_mask_o = '0;
    stat_lru_o = '0;
    stat_lru_mask_o = '0;

    tag_mem_v_o = 1'b0;
    tag_mem_w_o = 1'b0;
    tag_o = addr_tag;
    tag_valid_o = 1'b0;
    tag_mask_o = '0;

    recover_o = 1'b0;
    done_o = 1'b0;

    case (state_r)
      ST_IDLE: begin
        // status read, data arrives next cycle
        stat_mem_v_o = start;
        if (start) begin
          flush_way_n = tag_hit_way_i;
          state_n = goto_flush ? ST_FLUSH_OP : ST_SEND_FILL_ADDR;
        end
      end

      ST_FLUSH_OP: begin
        stat_mem_v_o = 1'b1;
        stat_mem_w_o = 1'b1;
        stat_dirty_mask_o = tag_hit_i;
        // AFL keeps the line, so the tag memory is left alone
        tag_mem_v_o = inval_op;
        tag_mem_w_o = 1'b1;
        tag_mask_o = tag_hit_i;
        if (op_i != OP_AINV && stat_dirty_i[flush_way_r] && valid_i[flush_way_r]) begin
          state_n = ST_SEND_EVICT_ADDR;
        end else begin
          state_n = ST_RECOVER;
        end
      end

      ST_SEND_FILL_ADDR: begin
        dma_cmd_o = DMA_SEND_FILL_ADDR;
        dma_addr_o = fill_addr;
        if (dma_done_i) begin
          chosen_way_n = victim_way_i;
          if (valid_i[victim_way_i] && stat_dirty_i[victim_way_i]) begin
            state_n = ST_SEND_EVICT_ADDR;
          end else begin
            state_n = ST_GET_FILL_DATA;
          end
        end
      end

      ST_SEND_EVICT_ADDR: begin
        dma_cmd_o = DMA_SEND_EVICT_ADDR;
        dma_addr_o = evict_addr;
        if (dma_done_i) begin
          state_n = ST_SEND_EVICT_DATA;
        end
      end

      ST_SEND_EVICT_DATA: begin
        dma_cmd_o = DMA_SEND_EVICT_DATA;
        dma_addr_o = evict_addr;
        if (dma_done_i) begin
          state_n = goto_flush ? ST_RECOVER : ST_GET_FILL_DATA;
        end
      end

      ST_GET_FILL_DATA: begin
        dma_cmd_o = DMA_GET_FILL_DATA;
        dma_addr_o = fill_addr;
        // new line becomes MRU, dirty only for a store
        stat_mem_v_o = dma_done_i;
        stat_mem_w_o = 1'b1;
        stat_dirty_o = {WAYS{op_i == OP_ST}};
        stat_dirty_mask_o = chosen_onehot;
        stat_lru_o = lru_data_i;
        stat_lru_mask_o = lru_mask_i;
        tag_mem_v_o = dma_done_i;
        tag_mem_w_o = 1'b1;
        tag_valid_o = 1'b1;
        tag_mask_o = chosen_onehot;
        if (dma_done_i) begin
          state_n = ST_RECOVER;
        end
      end

      ST_RECOVER: begin
        recover_o = 1'b1;
        state_n = ST_DONE;
      end

      ST_DONE: begin
        done_o = 1'b1;
        if (ack_i) begin
          state_n = ST_IDLE;
        end
      end

      default: begin
        state_n = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  // victim of the current miss and hit way of the current flush
  always_ff @(posedge clk_i) begin
    chosen_way_r <= chosen_way_n;
    flush_way_r <= flush_way_n;
  end

  // DMA engine is left idle while waiting for a miss or an ack
  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r inside {ST_IDLE, ST_DONE}) |-> (dma_cmd_o == DMA_NOP));

  assert property (@(posedge clk_i) disable iff (reset_i)
    !(done_o && recover_o));

endmodule

/* hw/cache_miss_pkg.sv */
// --------------------------------------------------------------------------
// Encodings shared by the miss handler and its neighbours.
// Holds the decoded cache operation, the DMA engine command and the
// miss FSM state. Port lists name these types with scoped names.
// --------------------------------------------------------------------------

package cache_miss_pkg;

  // decoded operation from the tag-verify stage
  typedef enum logic [2:0] {
    OP_LD     = 3'd0,
    OP_ST     = 3'd1,
    OP_AFL    = 3'd2,
    OP_AFLINV = 3'd3,
    OP_AINV   = 3'd4
  } cache_op_e;

  // command level held toward the DMA engine until dma_done_i
  typedef enum logic [2:0] {
    DMA_NOP              = 3'd0,
    DMA_SEND_FILL_ADDR   = 3'd1,
    DMA_SEND_EVICT_ADDR  = 3'd2,
    DMA_GET_FILL_DATA    = 3'd3,
    DMA_SEND_EVICT_DATA  = 3'd4
  } dma_cmd_e;

  // miss/flush FSM state
  typedef enum logic [2:0] {
    ST_IDLE            = 3'd0,
    ST_FLUSH_OP        = 3'd1,
    ST_SEND_FILL_ADDR  = 3'd2,
    ST_SEND_EVICT_ADDR = 3'd3,
    ST_SEND_EVICT_DATA = 3'd4,
    ST_GET_FILL_DATA   = 3'd5,
    ST_RECOVER         = 3'd6,
    ST_DONE            = 3'd7
  } miss_state_e;

endpackage

/* hw/cache_victim_select.sv */
// --------------------------------------------------------------------------
// Replacement way selection for one set.
// Prefers the lowest-numbered invalid way, otherwise walks the pseudo-tree
// LRU bits. Purely combinational; the miss FSM registers the result.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_victim_select (
  input  logic [cache_geom_pkg::WAYS-1:0]      valid_i,
  input  logic [cache_geom_pkg::LRU_WIDTH-1:0] lru_i,
  output logic [cache_geom_pkg::LG_WAYS-1:0]   victim_way_o
);

  import cache_geom_pkg::*;

  logic               invalid_found;
  logic [LG_WAYS-1:0] invalid_way;
  logic [LG_WAYS-1:0] lru_way;

  // scan from the top so the lowest invalid way wins
  always_comb begin
    invalid_found = 1'b0;
    invalid_way = '0;
    for (int i = WAYS - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        invalid_found = 1'b1;
        invalid_way = LG_WAYS'(i);
      end
    end
  end

  // root bit picks the pair, then the pair's own bit picks the way
  always_comb begin
    lru_way[1] = lru_i[0];
    if (lru_i[0]) begin
      lru_way[0] = lru_i[2];
    end else begin
      lru_way[0] = lru_i[1];
    end
  end

  assign victim_way_o = invalid_found ? invalid_way : lru_way;

  // never replace a valid line while an invalid one is free
  always_comb begin
    assert final (victim_way_o < WAYS && (&valid_i || !valid_i[victim_way_o]))
      else $error("victim way %0d out of range or valid with free ways", victim_way_o);
  end

endmodule

/* test/cache_miss_tb.sv */
// ----------------------------------------------------------------------------
// Testbench for the cache miss handler.
// Applies a table of load/store misses and flush ops, answers DMA commands
// after a random delay and acks done after a per-entry delay. Checks the
// DMA sequence, tag and status writes and the recover/done timing.
// ----------------------------------------------------------------------------

`timescale 1ns/1ps

module cache_miss_tb;

  import cache_geom_pkg::*;
  import cache_miss_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam logic [31:0] SEED = 32'hd4fb_5070;

  typedef struct packed {
    cache_op_e                      op;
    logic [ADDR_WIDTH-1:0]          addr;
    logic [WAYS-1:0]                valid;
    logic [WAYS-1:0]                dirty;
    logic [LRU_WIDTH-1:0]           lru;
    logic [WAYS-1:0][TAG_WIDTH-1:0] tags;
    logic [WAYS-1:0]                hit;
    logic [LG_WAYS-1:0]             hit_way;
    logic [LG_WAYS-1:0]             exp_way;
    logic                           exp_evict;
    logic                           exp_dirty;
    logic [LRU_WIDTH-1:0]           exp_lru;
    logic [LRU_WIDTH-1:0]           exp_lru_mask;
    logic [3:0]                     ack_delay;
    logic [3:0]                     sbuf_hold;
  } entry_t;

  logic                           clk_i;
  logic                           reset_i;
  logic                           miss_v_i;
  cache_op_e                      op_i;
  logic [ADDR_WIDTH-1:0]          addr_i;
  logic [WAYS-1:0]                valid_i;
  logic [WAYS-1:0][TAG_WIDTH-1:0] tag_i;
  logic [WAYS-1:0]                tag_hit_i;
  logic [LG_WAYS-1:0]             tag_hit_way_i;
  logic                           tag_hit_found_i;
  logic                           sbuf_empty_i;
  logic [WAYS-1:0]                stat_dirty_i;
  logic [LRU_WIDTH-1:0]           stat_lru_i;
  dma_cmd_e                       dma_cmd_o;
  logic [LG_WAYS-1:0]             dma_way_o;
  logic [ADDR_WIDTH-1:0]          dma_addr_o;
  logic                           dma_done_i;
  logic                           stat_mem_v_o;
  logic                           stat_mem_w_o;
  logic [LG_SETS-1:0]             stat_mem_addr_o;
  logic [WAYS-1:0]                stat_dirty_o;
  logic [WAYS-1:0]                stat_dirty_mask_o;
  logic [LRU_WIDTH-1:0]           stat_lru_o;
  logic [LRU_WIDTH-1:0]           stat_lru_mask_o;
  logic                           tag_mem_v_o;
  logic                           tag_mem_w_o;
  logic [LG_SETS-1:0]             tag_mem_addr_o;
  logic [TAG_WIDTH-1:0]           tag_o;
  logic                           tag_valid_o;
  logic [WAYS-1:0]                tag_mask_o;
  logic                           recover_o;
  logic                           done_o;
  logic [LG_WAYS-1:0]             chosen_way_o;
  logic                           busy_o;
  logic                           ack_i;

  entry_t table_q[$];

  cache_miss cache_miss_i (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic add_entry(input cache_op_e op, input logic [31:0] addr,
                           input logic [3:0] valid, input logic [3:0] dirty,
                           input logic [2:0] lru, input logic [3:0] hit,
                           input logic [1:0] hit_way, input logic [1:0] exp_way,
                           input logic exp_evict, input logic exp_dirty,
                           input logic [2:0] exp_lru, input logic [2:0] exp_lru_mask,
                           input logic [3:0] ack_delay, input logic [3:0] sbuf_hold);
    entry_t e;
    e = '{op, addr, valid, dirty, lru, '0, hit, hit_way, exp_way, exp_evict,
          exp_dirty, exp_lru, exp_lru_mask, ack_delay, sbuf_hold};
    for (int w = 0; w < WAYS; w++) begin
      e.tags[w] = TAG_WIDTH'(32'h0_5a00 + 32'(table_q.size()) * 32'h40 + 32'(w));
    end
    // a hit way holds the request's own tag
    if (hit != '0) begin
      e.tags[hit_way] = addr[ADDR_WIDTH-1:TAG_OFFSET];
    end
    table_q.push_back(e);
  endtask

  // op addr valid dirty lru hit hit_way | way evict dirty lru lru_mask | ack sbuf
  task automatic build_table();
    add_entry(OP_LD, 32'h1234_5678, 4'b1011, 4'b1111, 3'b000, 4'b0000, 2'd0,
              2'd2, 1'b0, 1'b0, 3'b100, 3'b101, 4'd2, 4'd3);
    add_entry(OP_ST, 32'hcafe_0140, 4'b1111, 4'b0010, 3'b010, 4'b0000, 2'd0,
              2'd1, 1'b1, 1'b1, 3'b001, 3'b011, 4'd0, 4'd0);
    add_entry(OP_ST, 32'h0bad_f00d, 4'b1111, 4'b0111, 3'b101, 4'b0000, 2'd0,
              2'd3, 1'b0, 1'b1, 3'b000, 3'b101, 4'd1, 4'd1);
    add_entry(OP_LD, 32'h8000_07e0, 4'b1111, 4'b0001, 3'b100, 4'b0000, 2'd0,
              2'd0, 1'b1, 1'b0, 3'b011, 3'b011, 4'd3, 4'd0);
    add_entry(OP_AFL, 32'h4444_4444, 4'b1111, 4'b0100, 3'b000, 4'b0100, 2'd2,
              2'd2, 1'b1, 1'b0, 3'b000, 3'b000, 4'd1, 4'd2);
    add_entry(OP_AFLINV, 32'h7654_3210, 4'b0111, 4'b0010, 3'b000, 4'b0010, 2'd1,
              2'd1, 1'b1, 1'b0, 3'b000, 3'b000, 4'd0, 4'd0);
    add_entry(OP_AINV, 32'h0000_1fe0, 4'b1111, 4'b1000, 3'b000, 4'b1000, 2'd3,
              2'd3, 1'b0, 1'b0, 3'b000, 3'b000, 4'd2, 4'd1);
  endtask

  task automatic run_entry(input entry_t e);
    logic [ADDR_WIDTH-1:0] fill_addr;
    logic [ADDR_WIDTH-1:0] evict_addr;
    logic [WAYS-1:0]       way_mask;
    logic                  is_miss;
    logic                  done_seen;
    dma_cmd_e              exp_cmd_q[$];
    logic [ADDR_WIDTH-1:0] exp_addr_q[$];
    int                    cmd_idx;
    int                    cyc;
    int                    last_done_cyc;
    int                    recover_cyc;
    int                    read_cnt;
    int                    stat_wr_cnt;
    int                    tag_wr_cnt;

    is_miss = (e.op == OP_LD) || (e.op == OP_ST);
    way_mask = WAYS'(1) << e.exp_way;
    fill_addr = {e.addr[ADDR_WIDTH-1:BLOCK_OFFSET_WIDTH], {BLOCK_OFFSET_WIDTH{1'b0}}};
    evict_addr = {e.tags[e.exp_way], e.addr[TAG_OFFSET-1:BLOCK_OFFSET_WIDTH],
                  {BLOCK_OFFSET_WIDTH{1'b0}}};

    // expected DMA order: fill address, optional eviction, fill data
    if (is_miss) begin
      exp_cmd_q.push_back(DMA_SEND_FILL_ADDR);
      exp_addr_q.push_back(fill_addr);
    end
    if (e.exp_evict) begin
      exp_cmd_q.push_back(DMA_SEND_EVICT_ADDR);
      exp_addr_q.push_back(evict_addr);
      exp_cmd_q.push_back(DMA_SEND_EVICT_DATA);
      exp_addr_q.push_back(evict_addr);
    end
    if (is_miss) begin
      exp_cmd_q.push_back(DMA_GET_FILL_DATA);
      exp_addr_q.push_back(fill_addr);
    end

    @(posedge clk_i);
    op_i <= e.op;
    addr_i <= e.addr;
    valid_i <= e.valid;
    tag_i <= e.tags;
    tag_hit_i <= e.hit;
    tag_hit_way_i <= e.hit_way;
    tag_hit_found_i <= |e.hit;
    stat_dirty_i <= e.dirty;
    stat_lru_i <= e.lru;
    miss_v_i <= 1'b1;
    sbuf_empty_i <= (e.sbuf_hold == 4'd0);

    // store buffer still draining, so nothing may start
    for (int i = 0; i < int'(e.sbuf_hold); i++) begin
      @(posedge clk_i);
      check_value("busy_o", 64'(busy_o), 64'd0);
      check_value("stat_mem_v_o", 64'(stat_mem_v_o), 64'd0);
    end
    sbuf_empty_i <= 1'b1;

    cmd_idx = 0;
    cyc = 0;
    last_done_cyc = -1;
    recover_cyc = -1;
    read_cnt = 0;
    stat_wr_cnt = 0;
    tag_wr_cnt = 0;
    done_seen = 1'b0;
    while (!done_seen && cyc < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cyc++;
      if (stat_mem_v_o && !stat_mem_w_o) begin
        read_cnt++;
        check_value("stat_mem_addr_o", 64'(stat_mem_addr_o),
                    64'(e.addr[TAG_OFFSET-1:BLOCK_OFFSET_WIDTH]));
      end
      if (dma_done_i && dma_cmd_o != DMA_NOP) begin
        if (cmd_idx >= exp_cmd_q.size()) begin
          abort_run("DMA command issued after the expected sequence was complete");
        end else begin
          check_value("dma_cmd_o", 64'(dma_cmd_o), 64'(exp_cmd_q[cmd_idx]));
          check_value("dma_addr_o", 64'(dma_addr_o), 64'(exp_addr_q[cmd_idx]));
          if (dma_cmd_o != DMA_SEND_FILL_ADDR) begin
            check_value("dma_way_o", 64'(dma_way_o), 64'(e.exp_way));
          end
          cmd_idx++;
          last_done_cyc = cyc;
        end
      end
      if (stat_mem_v_o && stat_mem_w_o) begin
        stat_wr_cnt++;
        check_value("stat_dirty_mask_o", 64'(stat_dirty_mask_o), 64'(way_mask));
        check_value("stat_dirty_o", 64'(stat_dirty_o[e.exp_way]), 64'(e.exp_dirty));
        check_value("stat_lru_o", 64'(stat_lru_o & stat_lru_mask_o), 64'(e.exp_lru));
        check_value("stat_lru_mask_o", 64'(stat_lru_mask_o), 64'(e.exp_lru_mask));
      end
      if (tag_mem_v_o) begin
        tag_wr_cnt++;
        check_value("tag_mem_w_o", 64'(tag_mem_w_o), 64'd1);
        check_value("tag_mem_addr_o", 64'(tag_mem_addr_o),
                    64'(e.addr[TAG_OFFSET-1:BLOCK_OFFSET_WIDTH]));
        check_value("tag_mask_o", 64'(tag_mask_o), 64'(way_mask));
        check_value("tag_valid_o", 64'(tag_valid_o), 64'(is_miss));
        if (is_miss) begin
          check_value("tag_o", 64'(tag_o), 64'(e.addr[ADDR_WIDTH-1:TAG_OFFSET]));
        end
      end
      if (recover_o) begin
        recover_cyc = cyc;
        check_value("busy_o", 64'(busy_o), 64'd1);
      end
      if (done_o) begin
        done_seen = 1'b1;
      end
    end
    if (!done_seen) begin
      abort_run("timeout while waiting for done_o from the miss handler");
    end

    check_value("dma_cmd_o count", 64'(cmd_idx), 64'(exp_cmd_q.size()));
    check_value("stat_mem_v_o read count", 64'(read_cnt), 64'd1);
    check_value("stat_mem_v_o write count", 64'(stat_wr_cnt), 64'd1);
    check_value("tag_mem_v_o count", 64'(tag_wr_cnt), 64'(e.op != OP_AFL));
    check_value("done_o delay after recover_o", 64'(cyc - recover_cyc), 64'd1);
    if (last_done_cyc >= 0) begin
      check_value("recover_o delay after dma_done_i", 64'(recover_cyc - last_done_cyc), 64'd1);
    end
    if (is_miss) begin
      check_value("chosen_way_o", 64'(chosen_way_o), 64'(e.exp_way));
    end

    // done must hold until the pipeline acks
    for (int i = 0; i < int'(e.ack_delay); i++) begin
      @(posedge clk_i);
      check_value("done_o", 64'(done_o), 64'd1);
      check_value("busy_o", 64'(busy_o), 64'd0);
    end
    ack_i <= 1'b1;
    miss_v_i <= 1'b0;
    @(posedge clk_i);
    check_value("done_o", 64'(done_o), 64'd1);
    ack_i <= 1'b0;
    @(posedge clk_i);
    check_value("done_o", 64'(done_o), 64'd0);
    check_value("busy_o", 64'(busy_o), 64'd0);
    check_value("dma_cmd_o", 64'(dma_cmd_o), 64'(DMA_NOP));
  endtask

  // answers each DMA command after 1 to 4 cycles with a one-cycle done
  initial begin
    int unsigned delay_left;
    void'($urandom(SEED));
    delay_left = 0;
    dma_done_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      if (dma_done_i) begin
        dma_done_i <= 1'b0;
      end else if (!reset_i && dma_cmd_o != DMA_NOP) begin
        if (delay_left == 0) begin
          delay_left = ($urandom % 4) + 1;
        end
        delay_left--;
        if (delay_left == 0) begin
          dma_done_i <= 1'b1;
        end
      end
    end
  end

  initial begin
    reset_i <= 1'b1;
    miss_v_i <= 1'b0;
    op_i <= OP_LD;
    addr_i <= '0;
    valid_i <= '0;
    tag_i <= '0;
    tag_hit_i <= '0;
    tag_hit_way_i <= '0;
    tag_hit_found_i <= 1'b0;
    sbuf_empty_i <= 1'b1;
    stat_dirty_i <= '0;
    stat_lru_i <= '0;
    ack_i <= 1'b0;
    build_table();

    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_value("busy_o", 64'(busy_o), 64'd0);
    check_value("done_o", 64'(done_o), 64'd0);
    check_value("recover_o", 64'(recover_o), 64'd0);
    check_value("dma_cmd_o", 64'(dma_cmd_o), 64'(DMA_NOP));

    for (int i = 0; i < table_q.size(); i++) begin
      run_entry(table_q[i]);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
